//--- Bender.yml
package:
  name: mips_apb_core

sources:
  - cpuPkg.sv
  - instrFetch.sv
  - control32.sv
  - decodeExecute.sv
  - memOrIo.sv
  - mipsTop.sv
  - target: simulation
    files:
      - mipsTb.sv

//--- control32.sv
`timescale 1ns/10ps

module control32 (
  input  logic [31:0]  instr,
  input  logic [21:0]  aluResultHigh, // address bits 31:10 from the alu
  output cpuPkg::ctrlT ctrl
);

  logic [5:0] opcode;
  logic [5:0] func;
  logic       rFormat;
  logic       lw;
  logic       sw;
  logic       isIo;

  assign opcode = instr[31:26];
  assign func   = instr[5:0];

  assign rFormat = (opcode == cpuPkg::rOp);
  assign lw      = (opcode == cpuPkg::lwOp);
  assign sw      = (opcode == cpuPkg::swOp);
  assign isIo    = (aluResultHigh == cpuPkg::ioMemTag); // io space tag

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    ctrl = '0;

    ctrl.iFormat = (opcode[5:3] == 3'b001);        // addi..lui
    ctrl.regDst  = rFormat;                        // rd for r-type
    ctrl.jr      = rFormat && (func == cpuPkg::jrFunc);
    ctrl.jmp     = (opcode == cpuPkg::jOp);
    ctrl.jal     = (opcode == cpuPkg::jalOp);
    ctrl.branch  = (opcode == cpuPkg::beqOp);
    ctrl.nBranch = (opcode == cpuPkg::bneOp);

    // jr has no destination
    ctrl.regWrite = (rFormat || lw || ctrl.jal || ctrl.iFormat) && !ctrl.jr;

    // loads and stores split on the address tag
    ctrl.memRead  = lw && !isIo;
    ctrl.memWrite = sw && !isIo;
    ctrl.ioRead   = lw && isIo;
    ctrl.ioWrite  = sw && isIo;

    ctrl.sftmd  = rFormat && (func[5:3] == 3'b000);     // sll, srl
    ctrl.aluOp  = {(rFormat || ctrl.iFormat), (ctrl.branch || ctrl.nBranch)};
    ctrl.aluSrc = ctrl.iFormat || lw || sw;             // imm into operand b
  end

endmodule

//--- cpuPkg.sv
package cpuPkg;

  ////////////////////////////////////////////////////////////
  // opcodes, instr[31:26]
  ////////////////////////////////////////////////////////////
  localparam logic [5:0] rOp    = 6'b000000;
  localparam logic [5:0] jOp    = 6'b000010;
  localparam logic [5:0] jalOp  = 6'b000011;
  localparam logic [5:0] beqOp  = 6'b000100;
  localparam logic [5:0] bneOp  = 6'b000101;
  localparam logic [5:0] addiOp = 6'b001000;
  localparam logic [5:0] sltiOp = 6'b001010;
  localparam logic [5:0] andiOp = 6'b001100;
  localparam logic [5:0] oriOp  = 6'b001101;
  localparam logic [5:0] luiOp  = 6'b001111;
  localparam logic [5:0] lwOp   = 6'b100011;
  localparam logic [5:0] swOp   = 6'b101011;

  // function codes, r-type only
  localparam logic [5:0] sllFunc = 6'b000000;
  localparam logic [5:0] srlFunc = 6'b000010;
  localparam logic [5:0] jrFunc  = 6'b001000;
  localparam logic [5:0] addFunc = 6'b100000;
  localparam logic [5:0] subFunc = 6'b100010;
  localparam logic [5:0] andFunc = 6'b100100;
  localparam logic [5:0] orFunc  = 6'b100101;
  localparam logic [5:0] sltFunc = 6'b101010;

  localparam logic [21:0] ioMemTag = 22'h3f_ffff; // upper address bits of io space

  localparam int romDepth = 64;  // words
  localparam int ramDepth = 256; // words

  ////////////////////////////////////////////////////////////
  // control word, 16 bits
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic       jr;
    logic       regDst;   // rd, else rt
    logic       aluSrc;   // immediate as operand b
    logic       regWrite;
    logic       memWrite;
    logic       memRead;
    logic       branch;   // beq
    logic       nBranch;  // bne
    logic       jmp;
    logic       jal;
    logic       iFormat;  // alu immediates, not lw/sw/beq/bne
    logic       sftmd;    // sll / srl
    logic [1:0] aluOp;    // {r or imm, branch}
    logic       ioRead;
    logic       ioWrite;
  } ctrlT;

  // apb requester outputs, 67 bits
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apbReqT;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
  } apbRspT;

endpackage

//--- decodeExecute.sv
`timescale 1ns/10ps

module decodeExecute (
  input  logic         clock,
  input  logic         rstN,
  input  logic         stall,
  input  logic [31:0]  instr,
  input  logic [31:0]  pcPlus4,
  input  cpuPkg::ctrlT ctrl,
  input  logic [31:0]  loadData,  // ram or prdata
  output logic [31:0]  aluResult,
  output logic [31:0]  storeData,
  output logic [31:0]  readData1,
  output logic         zero
);

  logic [5:0]  opcode;
  logic [5:0]  func;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  rd;
  logic [4:0]  shamt;
  logic [15:0] imm;
  logic [4:0]  writeReg;
  logic [31:0] readData2;
  logic [31:0] immExt;
  logic [31:0] aluB;
  logic [31:0] writeData;
  logic        zeroExt;
  logic        regWe;

  logic [31:0] regs [32];

  // instruction fields
  assign opcode = instr[31:26];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign shamt  = instr[10:6];
  assign func   = instr[5:0];
  assign imm    = instr[15:0];

  ////////////////////////////////////////////////////////////
  // register file read, $0 hardwired
  ////////////////////////////////////////////////////////////
  assign readData1 = (rs == 5'd0) ? '0 : regs[rs];
  assign readData2 = (rt == 5'd0) ? '0 : regs[rt];
  assign storeData = readData2;     // sw data

  // andi / ori zero extend, rest sign extend
  assign zeroExt = (opcode == cpuPkg::andiOp) || (opcode == cpuPkg::oriOp);
  assign immExt  = zeroExt ? {16'b0, imm} : {{16{imm[15]}}, imm};
  assign aluB    = ctrl.aluSrc ? immExt : readData2;

  ////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////
  always_comb begin
    aluResult = readData1 + aluB;                 // lw, sw, addi, add
    if (ctrl.aluOp == 2'b01) begin
      aluResult = readData1 - aluB;               // beq / bne compare
    end else if (ctrl.sftmd) begin
      case (func)
        cpuPkg::sllFunc: aluResult = readData2 << shamt;
        cpuPkg::srlFunc: aluResult = readData2 >> shamt;
        default:         aluResult = readData2;
      endcase
    end else if (ctrl.aluOp[1] && ctrl.iFormat) begin
      case (opcode)
        cpuPkg::andiOp: aluResult = readData1 & aluB;
        cpuPkg::oriOp:  aluResult = readData1 | aluB;
        cpuPkg::sltiOp: aluResult = {31'b0, $signed(readData1) < $signed(aluB)};
        cpuPkg::luiOp:  aluResult = {imm, 16'b0};
        default:        aluResult = readData1 + aluB; // addi
      endcase
    end else if (ctrl.aluOp[1]) begin
      case (func)
        cpuPkg::subFunc: aluResult = readData1 - aluB;
        cpuPkg::andFunc: aluResult = readData1 & aluB;
        cpuPkg::orFunc:  aluResult = readData1 | aluB;
        cpuPkg::sltFunc: aluResult = {31'b0, $signed(readData1) < $signed(aluB)};
        default:         aluResult = readData1 + aluB; // add, jr
      endcase
    end
  end

  assign zero = (aluResult == '0);

  ////////////////////////////////////////////////////////////
  // write back
  ////////////////////////////////////////////////////////////
  assign writeReg = ctrl.jal ? 5'd31 : (ctrl.regDst ? rd : rt); // $ra for jal

  always_comb begin
    if (ctrl.jal) writeData = pcPlus4;
    else if (ctrl.memRead || ctrl.ioRead) writeData = loadData;
    else writeData = aluResult;
  end

  // no write while an io access waits, $0 never written
  assign regWe = ctrl.regWrite && !stall && (writeReg != 5'd0);

  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (regWe) begin
      regs[writeReg] <= writeData;
    end
  end

  // $0 stays zero across every retired instruction
  regZeroHeld: assert property (@(posedge clock) disable iff (!rstN)
    regs[0] == '0);

endmodule

//--- instrFetch.sv
`timescale 1ns/10ps

module instrFetch (
  input  logic         clock,
  input  logic         rstN,
  input  logic         stall,     // io access in flight
  input  cpuPkg::ctrlT ctrl,
  input  logic         zero,
  input  logic [31:0]  jrTarget,  // rs value
  output logic [31:0]  instr,
  output logic [31:0]  pcPlus4
);

  logic [31:0] pc;
  logic [31:0] nextPc;
  logic [31:0] branchTarget;
  logic [31:0] jumpTarget;
  logic        branchTaken;

  // program rom, word addressed
  logic [31:0] rom [cpuPkg::romDepth];

  initial $readmemh("program.hex", rom);

  assign instr   = rom[pc[$clog2(cpuPkg::romDepth)+1:2]];
  assign pcPlus4 = pc + 32'd4;

  ////////////////////////////////////////////////////////////
  // next pc
  ////////////////////////////////////////////////////////////
  assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
  assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00}; // pseudo-direct
  assign branchTaken  = (ctrl.branch && zero) || (ctrl.nBranch && !zero);

  always_comb begin
    if (ctrl.jr) nextPc = jrTarget;                      // highest priority
    else if (ctrl.jmp || ctrl.jal) nextPc = jumpTarget;
    else if (branchTaken) nextPc = branchTarget;
    else nextPc = pcPlus4;
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= nextPc; // frozen while apb waits
    end
  end

  // a jump or branch must never leave the rom
  pcInRom: assert property (@(posedge clock) disable iff (!rstN)
    pc < cpuPkg::romDepth * 4);

endmodule

//--- memOrIo.sv
`timescale 1ns/10ps

module memOrIo (
  input  logic           clock,
  input  logic           rstN,
  input  cpuPkg::ctrlT   ctrl,
  input  logic [31:0]    aluResult,  // byte address
  input  logic [31:0]    storeData,
  output logic [31:0]    loadData,
  output logic           stall,
  output cpuPkg::apbReqT apbReq,
  input  cpuPkg::apbRspT apbRsp
);

  logic [31:0] ram [cpuPkg::ramDepth];
  logic [$clog2(cpuPkg::ramDepth)-1:0] ramAddr;

  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] paddr;
  logic [31:0] pwdata;
  logic        ioAccess;
  logic        done;

  ////////////////////////////////////////////////////////////
  // data ram
  ////////////////////////////////////////////////////////////
  assign ramAddr = aluResult[$clog2(cpuPkg::ramDepth)+1:2]; // word index

  always_ff @(posedge clock) begin
    if (ctrl.memWrite) ram[ramAddr] <= storeData;
  end

  assign loadData = ctrl.ioRead ? apbRsp.prdata : ram[ramAddr]; // async read

  ////////////////////////////////////////////////////////////
  // apb requester
  ////////////////////////////////////////////////////////////
  assign ioAccess = ctrl.ioRead || ctrl.ioWrite;
  assign done     = psel && penable && apbRsp.pready; // completing edge
  assign stall    = ioAccess && !done;

  // idle -> setup -> access, back to idle on pready
  always_ff @(posedge clock) begin
    if (!rstN) begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
    end else if (done) begin
      psel    <= 1'b0;  // forces an idle cycle between transfers
      penable <= 1'b0;
    end else if (psel) begin
      penable <= 1'b1;  // setup to access, then hold while waiting
    end else if (ioAccess) begin
      psel   <= 1'b1;
      pwrite <= ctrl.ioWrite;
    end
  end

  // address and data captured with the setup phase
  always_ff @(posedge clock) begin
    if (!psel && ioAccess) begin
      paddr  <= aluResult;
      pwdata <= storeData;
    end
  end

  assign apbReq = '{psel: psel, penable: penable, pwrite: pwrite,
                    paddr: paddr, pwdata: pwdata};

  penableNeedsPsel: assert property (@(posedge clock) disable iff (!rstN)
    apbReq.penable |-> apbReq.psel);

  // request held from setup until the transfer completes
  reqStable: assert property (@(posedge clock) disable iff (!rstN)
    apbReq.psel && !(apbReq.penable && apbRsp.pready) |=>
      $stable(apbReq.paddr) && $stable(apbReq.pwrite) && $stable(apbReq.pwdata));

  ioExclusive: assert property (@(posedge clock) disable iff (!rstN)
    !(ctrl.ioRead && ctrl.ioWrite));

endmodule

//--- mipsTb.sv
`timescale 1ns/10ps

module mipsTb;

  logic           clock;
  logic           rstN;
  cpuPkg::apbReqT apbOut;
  cpuPkg::apbRspT apbIn;

  integer      seed;
  int          waitLeft;     // access cycles left before pready
  int          writeIdx;     // next expected io write
  int          readCount;
  int          cycles;
  int          mismatches;
  int          protoErrors;
  int          otherErrors;
  logic [31:0] expAddr [15];
  logic [31:0] expData [15];

  mipsTop DUT (.clock(clock), .rstN(rstN), .apbOut(apbOut), .apbIn(apbIn));

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // which part of program.hex made write idx
  function automatic string behaviorOf(input int idx);
    if (idx < 9) return "aluOps";
    else if (idx < 11) return "shifts";
    else if (idx == 11) return "ramPath";
    else if (idx == 12) return "ioEcho";
    else return "controlFlow";
  endfunction

  ////////////////////////////////////////////////////////////
  // apb slave with 0..3 wait cycles per transfer
  ////////////////////////////////////////////////////////////
  always @(posedge clock) begin : responder
    int waits;
    if (!rstN) begin
      apbIn.pready <= 1'b0;
      waitLeft     <= 0;
    end else if (apbOut.psel && !apbOut.penable) begin
      waits = $unsigned($random(seed)) % 4;   // setup seen so plan the access
      waitLeft     <= waits;
      apbIn.pready <= (waits == 0);
      apbIn.prdata <= $random(seed);
    end else if (apbOut.psel && apbOut.penable && !apbIn.pready) begin
      waitLeft     <= waitLeft - 1;
      apbIn.pready <= (waitLeft == 1);
    end else begin
      apbIn.pready <= 1'b0;                   // completion or idle
    end
  end

  ////////////////////////////////////////////////////////////
  // completed transfers against the table
  ////////////////////////////////////////////////////////////
  always @(posedge clock) begin
    if (rstN && apbOut.psel && apbOut.penable && apbIn.pready) begin
      if (!apbOut.pwrite) begin
        // the only read is lw 48($1)
        readAddrCheck: assert (apbOut.paddr == 32'hffff_fc30)
          else begin
            mismatches++;
            $display("MISMATCH %s read: expected @ %h, actual @ %h",
                     behaviorOf(12), 32'hffff_fc30, apbOut.paddr);
          end
        readCount    <= readCount + 1;
        expData[12]  <= apbIn.prdata + 32'd5;  // program adds 5 and echoes it
      end else if (writeIdx >= $size(expData)) begin
        otherErrors++;
        $display("unexpected io write of %h to %h after the last expected one",
                 apbOut.pwdata, apbOut.paddr);
      end else begin
        writeCheck: assert (apbOut.paddr == expAddr[writeIdx] &&
                            apbOut.pwdata == expData[writeIdx])
          else begin
            mismatches++;
            $display("MISMATCH %s write %0d: expected %h @ %h, actual %h @ %h",
                     behaviorOf(writeIdx), writeIdx, expData[writeIdx],
                     expAddr[writeIdx], apbOut.pwdata, apbOut.paddr);
          end
        writeIdx <= writeIdx + 1;
      end
    end
  end

  // psel cleared by the first reset edge
  pselLowInReset: assert property (@(negedge clock) !rstN |-> !apbOut.psel)
    else begin
      protoErrors++;
      $display("psel high while reset is asserted");
    end

  setupThenAccess: assert property (@(posedge clock) disable iff (!rstN)
    apbOut.psel && !apbOut.penable |=> apbOut.psel && apbOut.penable)
    else begin
      protoErrors++;
      $display("setup cycle not followed by access");
    end

  heldUntilReady: assert property (@(posedge clock) disable iff (!rstN)
    apbOut.psel && !(apbOut.penable && apbIn.pready) |=>
      $stable(apbOut.paddr) && $stable(apbOut.pwrite) && $stable(apbOut.pwdata))
    else begin
      protoErrors++;
      $display("paddr, pwrite or pwdata moved before pready");
    end

  idleAfterDone: assert property (@(posedge clock) disable iff (!rstN)
    apbOut.psel && apbOut.penable && apbIn.pready |=> !apbOut.psel)
    else begin
      protoErrors++;
      $display("no idle cycle after a completed transfer");
    end

  // ram addresses must never reach the bus
  ioTagOnly: assert property (@(posedge clock) disable iff (!rstN)
    apbOut.psel |-> apbOut.paddr[31:10] == cpuPkg::ioMemTag)
    else begin
      protoErrors++;
      $display("apb transfer to a non-io address");
    end

  ////////////////////////////////////////////////////////////
  // reset, run, result
  ////////////////////////////////////////////////////////////
  initial begin
    seed        = 32'h5b00_9707;
    rstN        = 1'b0;
    apbIn       = '0;
    writeIdx    = 0;
    readCount   = 0;
    mismatches  = 0;
    protoErrors = 0;
    otherErrors = 0;
    for (int i = 0; i < 15; i++) begin
      expAddr[i] = 32'hffff_fc00 + 4 * ((i < 12) ? i : i + 1); // word 12 is the io read
    end
    expData = '{32'h0000_005d, 32'h0000_006b, 32'h0000_0060, 32'hffff_fffd,
                32'h0000_0001, 32'h0000_ff09, 32'h0000_8065, 32'h0000_0001,
                32'ha5c3_0000, 32'h5c30_0000, 32'h00a5_c300, 32'ha5c3_0000,
                32'h0000_0000, 32'h0000_00a0, 32'h0000_0064};
    repeat (2) @(posedge clock);
    rstN <= 1'b1;
    cycles = 0;
    while (writeIdx < $size(expData) && cycles < cpuPkg::romDepth * 8) begin
      @(posedge clock);
      cycles++;
    end
    repeat (8) @(negedge clock);  // room for a stray write after the last one
    if (writeIdx < $size(expData)) begin
      otherErrors++;
      $display("timeout after %0d cycles with %0d of %0d io writes seen",
               cycles, writeIdx, $size(expData));
    end
    if (readCount != 1) begin
      otherErrors++;
      $display("expected one io read, saw %0d", readCount);
    end
    $display("errors: %0d mismatch, %0d protocol, %0d other",
             mismatches, protoErrors, otherErrors);
    if (mismatches + protoErrors + otherErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- mipsTop.sv
`timescale 1ns/10ps

module mipsTop (
  input  logic           clock,
  input  logic           rstN,
  output cpuPkg::apbReqT apbOut,
  input  cpuPkg::apbRspT apbIn
);

  logic [31:0]  instr;
  logic [31:0]  pcPlus4;
  logic [31:0]  aluResult;
  logic [31:0]  storeData;
  logic [31:0]  readData1;   // jr target
  logic [31:0]  loadData;
  logic         zero;
  logic         stall;
  cpuPkg::ctrlT ctrl;

  ////////////////////////////////////////////////////////////
  // fetch, decode, execute, memory or io
  ////////////////////////////////////////////////////////////
  instrFetch uFetch (
    .clock(clock), .rstN(rstN), .stall(stall), .ctrl(ctrl), .zero(zero),
    .jrTarget(readData1), .instr(instr), .pcPlus4(pcPlus4)
  );

  control32 uCtrl (
    .instr(instr), .aluResultHigh(aluResult[31:10]), .ctrl(ctrl)
  );

  decodeExecute uExec (
    .clock(clock), .rstN(rstN), .stall(stall), .instr(instr), .pcPlus4(pcPlus4),
    .ctrl(ctrl), .loadData(loadData), .aluResult(aluResult),
    .storeData(storeData), .readData1(readData1), .zero(zero)
  );

  memOrIo uMem (
    .clock(clock), .rstN(rstN), .ctrl(ctrl), .aluResult(aluResult),
    .storeData(storeData), .loadData(loadData), .stall(stall),
    .apbReq(apbOut), .apbRsp(apbIn)
  );

endmodule

//--- program.hex
// one instruction word per line, rom word 0 first
// io base in $1 is ffff_fc00, each sw to it is one apb write
2001FC00 // addi $1,$0,-1024
20020064 // addi $2,$0,100
2003FFF9 // addi $3,$0,-7
00432020 // add  $4,$2,$3
AC240000 // sw   $4,0($1)
00432022 // sub
AC240004
00432024 // and
AC240008
00432025 // or
AC24000C
0062202A // slt  $4,$3,$2
AC240010
3064FF0F // andi $4,$3,0xff0f
AC240014
34448001 // ori  $4,$2,0x8001
AC240018
2864FFFA // slti $4,$3,-6
AC24001C
3C05A5C3 // lui  $5,0xa5c3
AC250020
00052100 // sll  $4,$5,4
AC240024
00052202 // srl  $4,$5,8
AC240028
AC050040 // sw   $5,64($0) to ram
8C060040 // lw   $6,64($0)
AC26002C
8C270030 // lw   $7,48($1) io read
20E70005 // addi $7,$7,5
AC270034
10420001 // beq  taken
AC200000 // skipped
1442FFFE // bne  not taken
1043FFFD // beq  not taken
14430001 // bne  taken
AC200000 // skipped
08000027 // j    39
AC200000 // skipped
0C00002A // jal  42
AC22003C // last write after return
08000029 // j    41, park
AC3F0038 // sw   $31,56($1) link value
03E00008 // jr   $31
AC200000 // skipped

//--- project.f
cpuPkg.sv
instrFetch.sv
control32.sv
decodeExecute.sv
memOrIo.sv
mipsTop.sv
mipsTb.sv
